//--- rtl/plic_pkg.sv
`default_nettype none

package plic_pkg;

  // Priority value width, priority 0 never interrupts
  localparam int PRIO_W = 3;

  // Source id width
  // Id 0 means no interrupt and real sources start at 1
  localparam int ID_W = 6;

  localparam int DATA_W = 32;  // Register bus data width

  // Address layout is {region, index}
  // The index selects a source for REG_PRIORITY and a target otherwise
  localparam int IDX_W  = 6;
  localparam int ADDR_W = IDX_W + 2;

  typedef logic [PRIO_W-1:0] prio_t;
  typedef logic [ID_W-1:0]   id_t;

  // Upper address bits of a register access
  typedef enum logic [1:0] {
    REG_PRIORITY  = 2'd0,  // Per-source priority
    REG_ENABLE    = 2'd1,  // Per-target enable mask, bit n-1 is source n
    REG_THRESHOLD = 2'd2,  // Per-target threshold
    REG_CLAIM     = 2'd3   // Read claims, write completes
  } plic_region_e;

endpackage

`default_nettype wire

//--- rtl/plic_gateway.sv
`timescale 1ns/1ns
`default_nettype none

module plic_gateway #(
  parameter int NUM_SOURCES = 8,
  parameter int NUM_TARGETS = 2
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [NUM_SOURCES-1:0]                irq_src_i,
  input  logic [NUM_SOURCES-1:0]                edge_sel_i,      // 1 is edge, 0 is level
  input  logic [NUM_TARGETS-1:0]                claim_req_i,
  input  logic [NUM_TARGETS-1:0]                complete_req_i,
  input  plic_pkg::id_t [NUM_TARGETS-1:0]       claim_id_i,
  input  plic_pkg::id_t [NUM_TARGETS-1:0]       complete_id_i,
  output logic [NUM_SOURCES-1:0]                pending_o
);

  logic [NUM_SOURCES-1:0] src_q;        // Source levels from the previous edge
  logic [NUM_SOURCES-1:0] req;
  logic [NUM_SOURCES-1:0] set_pending;
  logic [NUM_SOURCES-1:0] pending_q;
  logic [NUM_SOURCES-1:0] active_q;     // Claimed or pending, waiting for complete
  logic [NUM_SOURCES-1:0] claim;        // One-hot per source
  logic [NUM_SOURCES-1:0] complete;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_q <= '0;
    end else begin
      src_q <= irq_src_i;
    end
  end

  // Edge mode only sees a rise against the registered level
  assign req = (edge_sel_i & irq_src_i & ~src_q) | (~edge_sel_i & irq_src_i);

  // Decode ids from all targets, id 0 and ids past the last source match nothing
  always_comb begin
    claim    = '0;
    complete = '0;
    for (int t = 0; t < NUM_TARGETS; t++) begin
      for (int s = 0; s < NUM_SOURCES; s++) begin
        if (claim_req_i[t] && int'(claim_id_i[t]) == s + 1) begin
          claim[s] = 1'b1;
        end
        if (complete_req_i[t] && int'(complete_id_i[t]) == s + 1) begin
          complete[s] = 1'b1;
        end
      end
    end
  end

  // A new request is taken only once the previous one is fully retired
  assign set_pending = req & ~active_q & ~pending_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q | set_pending) & ~claim;
    end
  end

  // Active spans from the request until the target completes it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= '0;
    end else begin
      active_q <= (active_q | set_pending) & ~complete;
    end
  end

  assign pending_o = pending_q;

endmodule

`default_nettype wire

//--- rtl/plic_target.sv
`timescale 1ns/1ns
`default_nettype none

module plic_target #(
  parameter int NUM_SOURCES = 8
) (
  input  plic_pkg::prio_t [NUM_SOURCES-1:0] prio_i,       // Element n-1 is source n
  input  logic [NUM_SOURCES-1:0]            pending_i,
  input  logic [NUM_SOURCES-1:0]            enable_i,
  input  plic_pkg::prio_t                   threshold_i,
  output plic_pkg::id_t                     best_id_o,
  output logic                              irq_o
);

  plic_pkg::prio_t win_prio;
  plic_pkg::id_t   win_id;

  // Ascending scan with strict compare keeps the lowest id on a tie.
  // Starting from priority 0 also drops every priority-0 source.
  always_comb begin
    win_prio = '0;
    win_id   = '0;
    for (int s = 0; s < NUM_SOURCES; s++) begin
      if (pending_i[s] && enable_i[s] && (prio_i[s] > win_prio)) begin
        win_prio = prio_i[s];
        win_id   = plic_pkg::id_t'(s + 1);
      end
    end
  end

  assign irq_o = (win_id != '0) && (win_prio > threshold_i);

  // Below threshold the claim sees nothing
  assign best_id_o = irq_o ? win_id : '0;

endmodule

`default_nettype wire

//--- rtl/plic_regs.sv
`timescale 1ns/1ns
`default_nettype none

module plic_regs #(
  parameter int NUM_SOURCES = 8,
  parameter int NUM_TARGETS = 2
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    wr_en_i,
  input  logic                                    rd_en_i,
  input  logic [plic_pkg::ADDR_W-1:0]             addr_i,
  input  logic [plic_pkg::DATA_W-1:0]             wdata_i,
  output logic [plic_pkg::DATA_W-1:0]             rdata_o,
  input  plic_pkg::id_t [NUM_TARGETS-1:0]         best_id_i,
  output plic_pkg::prio_t [NUM_SOURCES-1:0]       prio_o,
  output logic [NUM_TARGETS-1:0][NUM_SOURCES-1:0] enable_o,
  output plic_pkg::prio_t [NUM_TARGETS-1:0]       threshold_o,
  output logic [NUM_TARGETS-1:0]                  claim_req_o,
  output plic_pkg::id_t [NUM_TARGETS-1:0]         claim_id_o,
  output logic [NUM_TARGETS-1:0]                  complete_req_o,
  output plic_pkg::id_t [NUM_TARGETS-1:0]         complete_id_o
);

  // Enable masks may be wider than the bus, upper bits stay unreachable
  localparam int EXT_W = (NUM_SOURCES > plic_pkg::DATA_W) ? NUM_SOURCES : plic_pkg::DATA_W;

  plic_pkg::plic_region_e                 region;
  logic [plic_pkg::IDX_W-1:0]             idx;
  logic [EXT_W-1:0]                       wdata_ext;
  logic [EXT_W-1:0]                       enable_ext;
  logic [plic_pkg::DATA_W-1:0]            rdata_d;
  plic_pkg::prio_t [NUM_SOURCES-1:0]      prio_q;
  logic [NUM_TARGETS-1:0][NUM_SOURCES-1:0] enable_q;
  plic_pkg::prio_t [NUM_TARGETS-1:0]      threshold_q;

  assign region    = plic_pkg::plic_region_e'(addr_i[plic_pkg::ADDR_W-1:plic_pkg::IDX_W]);
  assign idx       = addr_i[plic_pkg::IDX_W-1:0];
  assign wdata_ext = EXT_W'(wdata_i);

  // Priority index is the source id, so index 0 is never written
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio_q      <= '0;
      enable_q    <= '0;
      threshold_q <= '0;
    end else if (wr_en_i) begin
      for (int s = 0; s < NUM_SOURCES; s++) begin
        if (region == plic_pkg::REG_PRIORITY && int'(idx) == s + 1) begin
          prio_q[s] <= wdata_i[plic_pkg::PRIO_W-1:0];
        end
      end
      for (int t = 0; t < NUM_TARGETS; t++) begin
        if (region == plic_pkg::REG_ENABLE && int'(idx) == t) begin
          enable_q[t] <= wdata_ext[NUM_SOURCES-1:0];
        end
        if (region == plic_pkg::REG_THRESHOLD && int'(idx) == t) begin
          threshold_q[t] <= wdata_i[plic_pkg::PRIO_W-1:0];
        end
      end
    end
  end

  // Read mux, anything out of range stays zero
  always_comb begin
    rdata_d    = '0;
    enable_ext = '0;
    for (int s = 0; s < NUM_SOURCES; s++) begin
      if (region == plic_pkg::REG_PRIORITY && int'(idx) == s + 1) begin
        rdata_d[plic_pkg::PRIO_W-1:0] = prio_q[s];
      end
    end
    for (int t = 0; t < NUM_TARGETS; t++) begin
      if (int'(idx) == t) begin
        case (region)
          plic_pkg::REG_ENABLE: begin
            enable_ext = EXT_W'(enable_q[t]);
            rdata_d    = enable_ext[plic_pkg::DATA_W-1:0];
          end
          plic_pkg::REG_THRESHOLD: rdata_d[plic_pkg::PRIO_W-1:0] = threshold_q[t];
          plic_pkg::REG_CLAIM:     rdata_d[plic_pkg::ID_W-1:0] = best_id_i[t];
          default: ;
        endcase
      end
    end
  end

  // Held until the next read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_o <= '0;
    end else if (rd_en_i) begin
      rdata_o <= rdata_d;
    end
  end

  // Claim and complete strobes act on the gateway at the access edge
  always_comb begin
    for (int t = 0; t < NUM_TARGETS; t++) begin
      claim_req_o[t]    = rd_en_i && region == plic_pkg::REG_CLAIM && int'(idx) == t;
      complete_req_o[t] = wr_en_i && region == plic_pkg::REG_CLAIM && int'(idx) == t;
      claim_id_o[t]     = best_id_i[t];                  // Id returned by this read
      complete_id_o[t]  = wdata_i[plic_pkg::ID_W-1:0];
    end
  end

  assign prio_o      = prio_q;
  assign enable_o    = enable_q;
  assign threshold_o = threshold_q;

endmodule

`default_nettype wire

//--- rtl/plic_top.sv
`timescale 1ns/1ns
`default_nettype none

module plic_top #(
  parameter int NUM_SOURCES = 8,   // At most 63
  parameter int NUM_TARGETS = 2
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [NUM_SOURCES-1:0]        irq_src_i,
  input  logic [NUM_SOURCES-1:0]        edge_sel_i,
  input  logic                          wr_en_i,
  input  logic                          rd_en_i,
  input  logic [plic_pkg::ADDR_W-1:0]   addr_i,
  input  logic [plic_pkg::DATA_W-1:0]   wdata_i,
  output logic [plic_pkg::DATA_W-1:0]   rdata_o,
  output logic [NUM_TARGETS-1:0]        irq_o
);

  logic [NUM_SOURCES-1:0]                  pending;
  plic_pkg::prio_t [NUM_SOURCES-1:0]       prio;
  logic [NUM_TARGETS-1:0][NUM_SOURCES-1:0] enable;
  plic_pkg::prio_t [NUM_TARGETS-1:0]       threshold;
  plic_pkg::id_t [NUM_TARGETS-1:0]         best_id;
  logic [NUM_TARGETS-1:0]                  claim_req;
  plic_pkg::id_t [NUM_TARGETS-1:0]         claim_id;
  logic [NUM_TARGETS-1:0]                  complete_req;
  plic_pkg::id_t [NUM_TARGETS-1:0]         complete_id;

  plic_regs #(
    .NUM_SOURCES (NUM_SOURCES),
    .NUM_TARGETS (NUM_TARGETS)
  ) plic_regs_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr_en_i        (wr_en_i),
    .rd_en_i        (rd_en_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .rdata_o        (rdata_o),
    .best_id_i      (best_id),
    .prio_o         (prio),
    .enable_o       (enable),
    .threshold_o    (threshold),
    .claim_req_o    (claim_req),
    .claim_id_o     (claim_id),
    .complete_req_o (complete_req),
    .complete_id_o  (complete_id)
  );

  plic_gateway #(
    .NUM_SOURCES (NUM_SOURCES),
    .NUM_TARGETS (NUM_TARGETS)
  ) plic_gateway_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .irq_src_i      (irq_src_i),
    .edge_sel_i     (edge_sel_i),
    .claim_req_i    (claim_req),
    .complete_req_i (complete_req),
    .claim_id_i     (claim_id),
    .complete_id_i  (complete_id),
    .pending_o      (pending)
  );

  // One arbiter per hart, all share the pending vector
  for (genvar t = 0; t < NUM_TARGETS; t++) begin : g_target
    plic_target #(
      .NUM_SOURCES (NUM_SOURCES)
    ) plic_target_i (
      .prio_i      (prio),
      .pending_i   (pending),
      .enable_i    (enable[t]),
      .threshold_i (threshold[t]),
      .best_id_o   (best_id[t]),
      .irq_o       (irq_o[t])
    );
  end

endmodule

`default_nettype wire

//--- testbench/plic_tb.sv
`timescale 1ns/1ns
`default_nettype none

module plic_tb;

  localparam int NUM_SOURCES     = 8;   // DUT defaults
  localparam int NUM_TARGETS     = 2;
  localparam int NUM_TESTS       = 5;
  localparam int MAX_TEST_CYCLES = 400; // Longest test with margin
  localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_TEST_CYCLES;

  logic                          clk;
  logic                          rst_n;
  logic [NUM_SOURCES-1:0]        irq_src_i;
  logic [NUM_SOURCES-1:0]        edge_sel_i;
  logic                          wr_en_i;
  logic                          rd_en_i;
  logic [plic_pkg::ADDR_W-1:0]   addr_i;
  logic [plic_pkg::DATA_W-1:0]   wdata_i;
  logic [plic_pkg::DATA_W-1:0]   rdata_o;
  logic [NUM_TARGETS-1:0]        irq_o;

  int              errors     = 0;
  int              checks     = 0;
  int              test_start = 0;
  logic [31:0]     lcg_state  = 32'hbe777bc0;
  plic_pkg::prio_t model_prio [NUM_SOURCES];   // Priorities as programmed, source n at n-1

  plic_top plic_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .irq_src_i  (irq_src_i),
    .edge_sel_i (edge_sel_i),
    .wr_en_i    (wr_en_i),
    .rd_en_i    (rd_en_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .rdata_o    (rdata_o),
    .irq_o      (irq_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [plic_pkg::ADDR_W-1:0] reg_addr(input plic_pkg::plic_region_e region,
                                                          input int idx);
    return {region, plic_pkg::IDX_W'(idx)};
  endfunction

  // Highest priority wins, lowest id on a tie, priority 0 never
  function automatic plic_pkg::id_t best_model(input logic [NUM_SOURCES-1:0] mask);
    plic_pkg::prio_t best_prio;
    plic_pkg::id_t   best_id;
    best_prio = '0;
    best_id   = '0;
    for (int s = 0; s < NUM_SOURCES; s++) begin
      if (mask[s] && model_prio[s] > best_prio) begin
        best_prio = model_prio[s];
        best_id   = plic_pkg::id_t'(s + 1);
      end
    end
    return best_id;
  endfunction

  task automatic check_id(input plic_pkg::id_t exp_id, input plic_pkg::id_t got_id,
                          input string what);
    checks++;
    if (got_id !== exp_id) begin
      errors++;
      $display("Mismatch at %0t: %s, id expected %0d got %0d", $time, what, exp_id, got_id);
    end
  endtask

  task automatic check_irq(input logic [NUM_TARGETS-1:0] exp_irq, input string what);
    checks++;
    if (irq_o !== exp_irq) begin
      errors++;
      $display("Mismatch at %0t: %s, irq expected %b got %b", $time, what, exp_irq, irq_o);
    end
  endtask

  task automatic check_data(input logic [plic_pkg::DATA_W-1:0] exp_data, input string what);
    checks++;
    if (rdata_o !== exp_data) begin
      errors++;
      $display("Mismatch at %0t: %s, data expected %h got %h", $time, what, exp_data, rdata_o);
    end
  endtask

  // Called on a falling edge and returns on one
  task automatic bus_write(input plic_pkg::plic_region_e region, input int idx,
                           input logic [plic_pkg::DATA_W-1:0] data);
    addr_i  = reg_addr(region, idx);
    wdata_i = data;
    wr_en_i = 1'b1;
    @(posedge clk);
    @(negedge clk);
    wr_en_i = 1'b0;
  endtask

  task automatic bus_read(input plic_pkg::plic_region_e region, input int idx,
                          output logic [plic_pkg::DATA_W-1:0] data);
    addr_i  = reg_addr(region, idx);
    rd_en_i = 1'b1;
    @(posedge clk);
    @(negedge clk);
    rd_en_i = 1'b0;
    data    = rdata_o;
  endtask

  task automatic claim_expect(input int target, input plic_pkg::id_t exp_id, input string what);
    logic [plic_pkg::DATA_W-1:0] data;
    bus_read(plic_pkg::REG_CLAIM, target, data);
    check_id(exp_id, plic_pkg::id_t'(data), what);
  endtask

  task automatic complete(input int target, input plic_pkg::id_t id);
    bus_write(plic_pkg::REG_CLAIM, target, plic_pkg::DATA_W'(id));
  endtask

  task automatic set_prio(input int id, input plic_pkg::prio_t prio);
    model_prio[id-1] = prio;
    bus_write(plic_pkg::REG_PRIORITY, id, plic_pkg::DATA_W'(prio));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n      = 1'b0;
    irq_src_i  = '0;
    edge_sel_i = '0;
    wr_en_i    = 1'b0;
    rd_en_i    = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    for (int s = 0; s < NUM_SOURCES; s++) model_prio[s] = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic report_test(input string name);
    $display("Test %s done with %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  task automatic test_level_claim();
    logic [plic_pkg::DATA_W-1:0] data;
    apply_reset();
    check_data('0, "rdata after reset");
    set_prio(3, 3'd5);
    bus_write(plic_pkg::REG_ENABLE, 0, 32'h04);
    bus_write(plic_pkg::REG_THRESHOLD, 0, 32'd0);
    bus_read(plic_pkg::REG_PRIORITY, 3, data);
    check_data(32'd5, "priority readback");
    bus_read(plic_pkg::REG_ENABLE, 0, data);
    check_data(32'h04, "enable readback");
    irq_src_i[2] = 1'b1;
    check_irq(2'b00, "level before edge");
    wait_cycles(1);
    check_irq(2'b01, "level one cycle later");
    claim_expect(0, 6'd3, "level claim");
    check_irq(2'b00, "after level claim");
    wait_cycles(3);
    check_irq(2'b00, "held level before complete");
    complete(0, 6'd3);
    check_irq(2'b00, "at complete edge");
    wait_cycles(1);
    check_irq(2'b01, "level after complete");
    report_test("level_claim");
  endtask

  task automatic test_edge();
    apply_reset();
    set_prio(5, 3'd4);
    bus_write(plic_pkg::REG_ENABLE, 0, 32'h10);
    edge_sel_i[4] = 1'b1;
    irq_src_i[4]  = 1'b1;
    wait_cycles(1);
    irq_src_i[4]  = 1'b0;
    check_irq(2'b01, "edge pulse pending");
    claim_expect(0, 6'd5, "edge claim");
    check_irq(2'b00, "after edge claim");
    irq_src_i[4] = 1'b1;   // Second rise while still active, held past the complete
    wait_cycles(2);
    check_irq(2'b00, "second pulse ignored");
    complete(0, 6'd5);
    wait_cycles(2);
    check_irq(2'b00, "edge after complete");
    claim_expect(0, 6'd0, "edge claim after complete");
    irq_src_i[4] = 1'b0;
    report_test("edge");
  endtask

  task automatic test_arbitration();
    logic [NUM_SOURCES-1:0] remaining;
    plic_pkg::id_t          exp_id;
    for (int round = 0; round < 3; round++) begin
      apply_reset();
      for (int s = 1; s <= NUM_SOURCES; s++) begin
        set_prio(s, plic_pkg::prio_t'((next_rand() >> 16) % 7 + 1));
      end
      bus_write(plic_pkg::REG_ENABLE, 0, 32'hff);
      remaining = NUM_SOURCES'(next_rand() >> 8);
      if (remaining == '0) remaining = 8'h81;
      irq_src_i = remaining;
      wait_cycles(1);
      while (remaining != '0) begin
        exp_id = best_model(remaining);
        claim_expect(0, exp_id, "arbitration claim");
        remaining[int'(exp_id) - 1] = 1'b0;
      end
      claim_expect(0, 6'd0, "arbitration drained");
    end
    report_test("arbitration");
  endtask

  task automatic test_threshold_enable();
    logic [plic_pkg::DATA_W-1:0] data;
    apply_reset();
    set_prio(1, 3'd4);   // Equal to threshold
    set_prio(2, 3'd0);
    set_prio(6, 3'd7);   // Not enabled
    bus_write(plic_pkg::REG_ENABLE, 0, 32'h02);
    irq_src_i = 8'b0010_0011;
    wait_cycles(2);
    check_irq(2'b00, "priority 0 at threshold 0");
    claim_expect(0, 6'd0, "claim priority 0");
    bus_write(plic_pkg::REG_THRESHOLD, 0, 32'd4);
    bus_write(plic_pkg::REG_ENABLE, 0, 32'h03);
    bus_read(plic_pkg::REG_THRESHOLD, 0, data);
    check_data(32'd4, "threshold readback");
    check_irq(2'b00, "nothing above threshold");
    claim_expect(0, 6'd0, "claim below threshold");
    set_prio(1, 3'd5);
    check_irq(2'b01, "priority raised above threshold");
    claim_expect(0, 6'd1, "claim above threshold");
    report_test("threshold_enable");
  endtask

  task automatic test_two_targets();
    apply_reset();
    set_prio(4, 3'd3);
    bus_write(plic_pkg::REG_ENABLE, 0, 32'h08);
    bus_write(plic_pkg::REG_ENABLE, 1, 32'h08);
    irq_src_i[3] = 1'b1;
    wait_cycles(1);
    check_irq(2'b11, "both targets raised");
    claim_expect(0, 6'd4, "target 0 claim");
    check_irq(2'b00, "both cleared by one claim");
    claim_expect(1, 6'd0, "target 1 claim after target 0");
    complete(0, 6'd4);
    wait_cycles(1);
    check_irq(2'b11, "both raised after complete");
    claim_expect(1, 6'd4, "target 1 claim");
    report_test("two_targets");
  endtask

  initial begin
    rst_n      = 1'b0;
    irq_src_i  = '0;
    edge_sel_i = '0;
    wr_en_i    = 1'b0;
    rd_en_i    = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    test_level_claim();
    test_edge();
    test_arbitration();
    test_threshold_enable();
    test_two_targets();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
rtl/plic_pkg.sv
rtl/plic_gateway.sv
rtl/plic_target.sv
rtl/plic_regs.sv
rtl/plic_top.sv
testbench/plic_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= plic_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "All checks passed" $(LOG) || (echo "Simulation reported failure"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
